//--- avl_tx_req_macros.svh
`ifndef AVL_TX_REQ_MACROS_SVH
`define AVL_TX_REQ_MACROS_SVH

// avalon byte address width
`define AVL_ADDR_W 32

// one avalon beat carries 16 bytes
`define BEAT_BYTES 16

// requests must not cross this boundary
`define PAGE_BYTES 4096

// fifo levels up to which a new request may be queued
`define CMD_FIFO_OK_LVL 8
`define WRDAT_FIFO_OK_LVL 32

// read tracking limits
`define MAX_OUTSTANDING_RD 8
`define PNDRD_DEPTH 16

// interrupt lines from the avalon side
`define RXM_IRQ_NUM 4

`endif

//--- avl_tx_req_pkg.sv
`default_nettype none

`include "avl_tx_req_macros.svh"

package avl_tx_req_pkg;

  typedef logic [`AVL_ADDR_W-1:0] avl_addr_t;
  typedef logic [5:0]             burst_cnt_t;   // avalon burst count in beats
  typedef logic [9:0]             byte_cnt_t;    // segment or remaining read bytes
  typedef logic [12:0]            page_bytes_t;  // 1..4096 bytes to the boundary
  typedef logic [8:0]             dw_len_t;      // tlp length field
  typedef logic [3:0]             tag_t;
  typedef logic [63:0]            msi_addr_t;

  // request fsm
  typedef enum logic [3:0] {
    TX_IDLE,
    TX_WR_BURST,
    TX_WR_HOLD,
    TX_WR_PIPE,
    TX_WR_HDR,
    TX_RD_WAIT,
    TX_RD_HDR,
    TX_RD_PIPE,
    TX_MSI
  } tx_state_e;

  // pending read head tracking
  typedef enum logic [1:0] {
    PR_IDLE,
    PR_LATCH,
    PR_CHECK
  } pndrd_state_e;

endpackage

`default_nettype wire

//--- avl_tx_req_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "avl_tx_req_macros.svh"

module avl_tx_req_fsm
  import avl_tx_req_pkg::*;
(
  input  wire                     AvlClk_i,
  input  wire                     Rstn_i,
  input  wire                     tx_chip_select_i,
  input  wire                     tx_read_i,
  input  wire                     tx_write_i,
  input  wire  [3:0]              cmd_fifo_used_w_i,
  input  wire  [5:0]              wr_dat_fifo_used_w_i,
  input  wire                     master_enable_i,
  input  wire                     msi_en_i,
  input  wire  [`RXM_IRQ_NUM-1:0] irq_lines_i,
  input  wire                     wr_seg_end_i,
  input  wire                     wr_burst_done_i,
  input  wire                     rd_last_seg_i,
  input  wire                     rd_slot_free_i,
  output logic                    tx_wait_request_o,
  output logic                    sm_idle_o,
  output logic                    wr_beat_o,
  output logic                    wr_dat_fifo_eop_o,
  output logic                    wr_hdr_o,
  output logic                    rd_hdr_o,
  output logic                    rd_accept_o,
  output logic                    msi_hdr_o,
  output logic                    cmd_fifo_busy_o
);

  tx_state_e state;
  tx_state_e state_nxt;
  logic      cmd_ok;
  logic      wrdat_ok;
  logic      irq_any;
  logic      irq_q;
  logic      msi_pend;
  logic      wr_go;
  logic      rd_go;

  assign cmd_ok   = (cmd_fifo_used_w_i <= `CMD_FIFO_OK_LVL);
  assign wrdat_ok = (wr_dat_fifo_used_w_i <= `WRDAT_FIFO_OK_LVL);
  assign irq_any  = |irq_lines_i;

  // a pending msi holds off any new avalon command
  assign wr_go = master_enable_i & ~msi_pend & tx_chip_select_i & tx_write_i & cmd_ok & wrdat_ok;
  assign rd_go = master_enable_i & ~msi_pend & tx_chip_select_i & tx_read_i & ~tx_write_i &
                 rd_slot_free_i;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      irq_q    <= 1'b0;
      msi_pend <= 1'b0;
    end
    else
    begin
      irq_q <= irq_any;
      if (irq_any & ~irq_q & msi_en_i)  // rising edge, msi on
        msi_pend <= 1'b1;
      else if (state == TX_MSI)
        msi_pend <= 1'b0;
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state <= TX_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      TX_IDLE:
        if (msi_pend & cmd_ok & master_enable_i)
          state_nxt = TX_MSI;
        else if (wr_go)
          state_nxt = TX_WR_BURST;
        else if (rd_go)
          state_nxt = TX_RD_WAIT;
      TX_WR_BURST:
        if (wr_seg_end_i)
          state_nxt = TX_WR_PIPE;
        else if (!wrdat_ok)
          state_nxt = TX_WR_HOLD;  // data fifo filling up
      TX_WR_HOLD:
        if (wrdat_ok)
          state_nxt = TX_WR_BURST;
      TX_WR_PIPE:
        if (cmd_ok)
          state_nxt = TX_WR_HDR;
      TX_WR_HDR:
        state_nxt = wr_burst_done_i ? TX_IDLE : TX_WR_BURST;
      TX_RD_WAIT:
        if (cmd_ok)
          state_nxt = TX_RD_HDR;
      TX_RD_HDR:
        state_nxt = rd_last_seg_i ? TX_IDLE : TX_RD_PIPE;
      TX_RD_PIPE:
        state_nxt = TX_RD_WAIT;  // split select settles here
      TX_MSI:
        state_nxt = TX_IDLE;
      default:
        state_nxt = TX_IDLE;
    endcase
  end

  assign sm_idle_o   = (state == TX_IDLE);
  assign rd_accept_o = sm_idle_o & ~(msi_pend & cmd_ok & master_enable_i) & ~wr_go & rd_go;
  assign wr_beat_o   = (state == TX_WR_BURST) & tx_chip_select_i & tx_write_i;
  assign wr_dat_fifo_eop_o = wr_beat_o & wr_seg_end_i;
  assign wr_hdr_o    = (state == TX_WR_HDR);
  assign rd_hdr_o    = (state == TX_RD_HDR);
  assign msi_hdr_o   = (state == TX_MSI);

  assign tx_wait_request_o = ~((state == TX_WR_BURST) | rd_accept_o);

  assign cmd_fifo_busy_o = (state == TX_WR_BURST) | (state == TX_WR_HOLD) |
                           (state == TX_WR_PIPE) | (state == TX_WR_HDR) |
                           (state == TX_RD_WAIT) | msi_pend;

endmodule

`default_nettype wire

//--- avl_tx_wr_segmenter.sv
`timescale 1ns/1ps
`default_nettype none

`include "avl_tx_req_macros.svh"

module avl_tx_wr_segmenter
  import avl_tx_req_pkg::*;
(
  input  wire        AvlClk_i,
  input  wire        Rstn_i,
  input  wire        sm_idle_i,
  input  wire        wr_beat_i,
  input  wire        wr_hdr_i,
  input  avl_addr_t  tx_address_i,
  input  burst_cnt_t tx_burst_count_i,
  input  wire  [2:0] max_payload_code_i,
  output logic       wr_seg_end_o,
  output logic       wr_burst_done_o,
  output avl_addr_t  seg_addr_o,
  output dw_len_t    seg_len_o
);

  avl_addr_t  beat_addr;  // address of the next beat
  burst_cnt_t beats_left;
  byte_cnt_t  seg_bytes;
  byte_cnt_t  max_payload;

  // 128 bytes, anything larger is capped at 256
  assign max_payload = (max_payload_code_i == 3'b000) ? byte_cnt_t'(128) : byte_cnt_t'(256);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      beat_addr  <= '0;
      seg_addr_o <= '0;
      beats_left <= '0;
      seg_bytes  <= '0;
    end
    else if (sm_idle_i)
    begin
      beat_addr  <= {tx_address_i[`AVL_ADDR_W-1:4], 4'h0};
      seg_addr_o <= {tx_address_i[`AVL_ADDR_W-1:4], 4'h0};
      beats_left <= tx_burst_count_i;
      seg_bytes  <= '0;
    end
    else if (wr_beat_i)
    begin
      beat_addr  <= beat_addr + avl_addr_t'(`BEAT_BYTES);
      beats_left <= beats_left - 1'b1;
      seg_bytes  <= seg_bytes + byte_cnt_t'(`BEAT_BYTES);
    end
    else if (wr_hdr_i)
    begin
      seg_addr_o <= beat_addr;  // next segment starts here
      seg_bytes  <= '0;
    end
  end

  assign wr_seg_end_o = wr_beat_i &
                        ((beats_left == burst_cnt_t'(1)) |
                         (beat_addr[11:0] == 12'(`PAGE_BYTES - `BEAT_BYTES)) |
                         (seg_bytes == max_payload - byte_cnt_t'(`BEAT_BYTES)));

  assign wr_burst_done_o = (beats_left == '0);
  assign seg_len_o       = {1'b0, seg_bytes[9:2]};  // bytes to dws

endmodule

`default_nettype wire

//--- avl_tx_rd_segmenter.sv
`timescale 1ns/1ps
`default_nettype none

`include "avl_tx_req_macros.svh"

module avl_tx_rd_segmenter
  import avl_tx_req_pkg::*;
(
  input  wire        AvlClk_i,
  input  wire        Rstn_i,
  input  wire        sm_idle_i,
  input  wire        rd_hdr_i,
  input  avl_addr_t  tx_address_i,
  input  burst_cnt_t tx_burst_count_i,
  input  wire  [2:0] max_rd_code_i,
  output logic       rd_last_seg_o,
  output avl_addr_t  rd_addr_o,
  output dw_len_t    rd_len_o
);

  localparam logic [1:0] SEL_MAX    = 2'd0;
  localparam logic [1:0] SEL_REMAIN = 2'd1;
  localparam logic [1:0] SEL_PAGE   = 2'd2;

  byte_cnt_t   remain;
  byte_cnt_t   max_rd;
  page_bytes_t to_page;
  logic [1:0]  sel;
  logic [1:0]  sel_q;
  byte_cnt_t   rd_size;

  always_comb
  begin
    case (max_rd_code_i)
      3'b000:  max_rd = byte_cnt_t'(128);
      3'b001:  max_rd = byte_cnt_t'(256);
      default: max_rd = byte_cnt_t'(512);
    endcase
  end

  assign to_page = page_bytes_t'(`PAGE_BYTES) - {1'b0, rd_addr_o[11:0]};

  // smallest of remaining, page and max read size
  always_comb
  begin
    if ((remain <= max_rd) && (remain <= to_page))
      sel = SEL_REMAIN;
    else if ((to_page <= max_rd) && (remain > to_page))
      sel = SEL_PAGE;
    else
      sel = SEL_MAX;
  end

  always_comb
  begin
    case (sel_q)
      SEL_REMAIN: rd_size = remain;
      SEL_PAGE:   rd_size = byte_cnt_t'(to_page);  // at most 512 here
      default:    rd_size = max_rd;
    endcase
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      rd_addr_o <= '0;
      remain    <= '0;
      sel_q     <= SEL_MAX;
    end
    else
    begin
      sel_q <= sel;  // registered for timing, RD_PIPE covers the delay
      if (sm_idle_i)
      begin
        rd_addr_o <= {tx_address_i[`AVL_ADDR_W-1:4], 4'h0};
        remain    <= byte_cnt_t'(tx_burst_count_i * `BEAT_BYTES);
      end
      else if (rd_hdr_i)
      begin
        rd_addr_o <= rd_addr_o + avl_addr_t'(rd_size);
        remain    <= remain - rd_size;
      end
    end
  end

  assign rd_last_seg_o = (sel_q == SEL_REMAIN);
  assign rd_len_o      = {1'b0, rd_size[9:2]};

endmodule

`default_nettype wire

//--- avl_tx_pending_rd.sv
`timescale 1ns/1ps
`default_nettype none

`include "avl_tx_req_macros.svh"

module avl_tx_pending_rd
  import avl_tx_req_pkg::*;
(
  input  wire        AvlClk_i,
  input  wire        Rstn_i,
  input  wire        rd_accept_i,
  input  burst_cnt_t tx_burst_count_i,
  input  wire        txs_read_data_valid_i,
  output logic       rd_slot_free_o
);

  localparam int PTR_W = $clog2(`PNDRD_DEPTH);
  localparam int CNT_W = $clog2(`MAX_OUTSTANDING_RD + 1);

  burst_cnt_t   mem [`PNDRD_DEPTH];
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic         empty;
  pndrd_state_e state;
  pndrd_state_e state_nxt;
  burst_cnt_t   head_q;     // burst count of the oldest read
  burst_cnt_t   beat_cnt;
  logic         head_done;
  logic [CNT_W-1:0] rd_cnt;

  assign empty     = (wr_ptr == rd_ptr);
  assign head_done = (state == PR_CHECK) && (beat_cnt == head_q);

  always_ff @(posedge AvlClk_i)
  begin
    if (rd_accept_i)
      mem[wr_ptr[PTR_W-1:0]] <= tx_burst_count_i;
    if (state == PR_LATCH)
      head_q <= mem[rd_ptr[PTR_W-1:0]];
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      state  <= PR_IDLE;
    end
    else
    begin
      state <= state_nxt;
      if (rd_accept_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (state == PR_LATCH)
        rd_ptr <= rd_ptr + 1'b1;  // pop as the head is latched
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      PR_IDLE:
        if (!empty)
          state_nxt = PR_LATCH;
      PR_LATCH:
        state_nxt = PR_CHECK;
      PR_CHECK:
        if (head_done)
          state_nxt = empty ? PR_IDLE : PR_LATCH;
      default:
        state_nxt = PR_IDLE;
    endcase
  end

  // a beat in the completing cycle belongs to the next read
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      beat_cnt <= '0;
    else if (head_done)
      beat_cnt <= burst_cnt_t'(txs_read_data_valid_i);
    else if (txs_read_data_valid_i)
      beat_cnt <= beat_cnt + 1'b1;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      rd_cnt <= '0;
    else
    begin
      case ({rd_accept_i, head_done})
        2'b10:   rd_cnt <= rd_cnt + 1'b1;
        2'b01:   rd_cnt <= rd_cnt - 1'b1;
        default: rd_cnt <= rd_cnt;  // none or both
      endcase
    end
  end

  assign rd_slot_free_o = (rd_cnt < CNT_W'(`MAX_OUTSTANDING_RD));

endmodule

`default_nettype wire

//--- avl_tx_hdr_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "avl_tx_req_macros.svh"

module avl_tx_hdr_builder
  import avl_tx_req_pkg::*;
(
  input  wire       AvlClk_i,
  input  wire       Rstn_i,
  input  wire       wr_hdr_i,
  input  wire       rd_hdr_i,
  input  wire       msi_hdr_i,
  input  wire       rd_last_seg_i,
  input  avl_addr_t seg_addr_i,
  input  dw_len_t   seg_len_i,
  input  avl_addr_t rd_addr_i,
  input  dw_len_t   rd_len_i,
  input  msi_addr_t msi_addr_i,
  output logic      tx_req_wr_o,
  output logic      hdr_is_wr_o,
  output logic      hdr_is_rd_o,
  output logic      hdr_is_msi_o,
  output logic      hdr_is_64_o,
  output msi_addr_t hdr_addr_o,
  output dw_len_t   hdr_len_o,
  output tag_t      hdr_tag_o,
  output logic      hdr_last_rd_o
);

  tag_t tag_q;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      tag_q <= '0;
    else if (rd_hdr_i)
      tag_q <= tag_q + 1'b1;  // wraps at 16
  end

  always_comb
  begin
    if (msi_hdr_i)
    begin
      hdr_addr_o = msi_addr_i;
      hdr_len_o  = dw_len_t'(1);
    end
    else if (wr_hdr_i)
    begin
      hdr_addr_o = {{(64-`AVL_ADDR_W){1'b0}}, seg_addr_i};
      hdr_len_o  = seg_len_i;
    end
    else
    begin
      hdr_addr_o = {{(64-`AVL_ADDR_W){1'b0}}, rd_addr_i};
      hdr_len_o  = rd_len_i;
    end
  end

  assign tx_req_wr_o   = wr_hdr_i | rd_hdr_i | msi_hdr_i;
  assign hdr_is_wr_o   = wr_hdr_i;   // msi is flagged on its own
  assign hdr_is_rd_o   = rd_hdr_i;
  assign hdr_is_msi_o  = msi_hdr_i;
  assign hdr_is_64_o   = msi_hdr_i & (|msi_addr_i[63:32]);
  assign hdr_tag_o     = tag_q;
  assign hdr_last_rd_o = rd_hdr_i & rd_last_seg_i;

endmodule

`default_nettype wire

//--- avl_tx_req_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "avl_tx_req_macros.svh"

module avl_tx_req_top
  import avl_tx_req_pkg::*;
(
  input  wire                     AvlClk_i,
  input  wire                     Rstn_i,
  input  wire                     tx_chip_select_i,
  input  wire                     tx_read_i,
  input  wire                     tx_write_i,
  input  burst_cnt_t              tx_burst_count_i,
  input  avl_addr_t               tx_address_i,
  output logic                    tx_wait_request_o,
  input  wire  [3:0]              cmd_fifo_used_w_i,
  input  wire  [5:0]              wr_dat_fifo_used_w_i,
  output logic                    wr_dat_fifo_wr_req_o,
  output logic                    wr_dat_fifo_eop_o,
  output logic                    cmd_fifo_busy_o,
  input  wire  [31:0]             dev_csr_i,
  input  wire                     master_enable_i,
  input  wire  [15:0]             msi_csr_i,
  input  msi_addr_t               msi_addr_i,
  input  wire  [31:0]             pcie_irq_ena_i,
  input  wire  [`RXM_IRQ_NUM-1:0] rxm_irq_i,
  input  wire                     txs_read_data_valid_i,
  output logic                    tx_req_wr_o,
  output logic                    hdr_is_wr_o,
  output logic                    hdr_is_rd_o,
  output logic                    hdr_is_msi_o,
  output logic                    hdr_is_64_o,
  output msi_addr_t               hdr_addr_o,
  output dw_len_t                 hdr_len_o,
  output tag_t                    hdr_tag_o,
  output logic                    hdr_last_rd_o
);

  logic      sm_idle;
  logic      wr_beat;
  logic      wr_hdr;
  logic      rd_hdr;
  logic      rd_accept;
  logic      msi_hdr;
  logic      wr_seg_end;
  logic      wr_burst_done;
  logic      rd_last_seg;
  logic      rd_slot_free;
  avl_addr_t seg_addr;
  dw_len_t   seg_len;
  avl_addr_t rd_addr;
  dw_len_t   rd_len;

  assign wr_dat_fifo_wr_req_o = wr_beat;  // every accepted beat goes to the data fifo

  avl_tx_req_fsm u_fsm (
    .AvlClk_i             (AvlClk_i),
    .Rstn_i               (Rstn_i),
    .tx_chip_select_i     (tx_chip_select_i),
    .tx_read_i            (tx_read_i),
    .tx_write_i           (tx_write_i),
    .cmd_fifo_used_w_i    (cmd_fifo_used_w_i),
    .wr_dat_fifo_used_w_i (wr_dat_fifo_used_w_i),
    .master_enable_i      (master_enable_i),
    .msi_en_i             (msi_csr_i[0]),
    .irq_lines_i          (rxm_irq_i & pcie_irq_ena_i[`RXM_IRQ_NUM-1:0]),
    .wr_seg_end_i         (wr_seg_end),
    .wr_burst_done_i      (wr_burst_done),
    .rd_last_seg_i        (rd_last_seg),
    .rd_slot_free_i       (rd_slot_free),
    .tx_wait_request_o    (tx_wait_request_o),
    .sm_idle_o            (sm_idle),
    .wr_beat_o            (wr_beat),
    .wr_dat_fifo_eop_o    (wr_dat_fifo_eop_o),
    .wr_hdr_o             (wr_hdr),
    .rd_hdr_o             (rd_hdr),
    .rd_accept_o          (rd_accept),
    .msi_hdr_o            (msi_hdr),
    .cmd_fifo_busy_o      (cmd_fifo_busy_o)
  );

  avl_tx_wr_segmenter u_wr_seg (
    .AvlClk_i           (AvlClk_i),
    .Rstn_i             (Rstn_i),
    .sm_idle_i          (sm_idle),
    .wr_beat_i          (wr_beat),
    .wr_hdr_i           (wr_hdr),
    .tx_address_i       (tx_address_i),
    .tx_burst_count_i   (tx_burst_count_i),
    .max_payload_code_i (dev_csr_i[7:5]),   // max payload size field
    .wr_seg_end_o       (wr_seg_end),
    .wr_burst_done_o    (wr_burst_done),
    .seg_addr_o         (seg_addr),
    .seg_len_o          (seg_len)
  );

  avl_tx_rd_segmenter u_rd_seg (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .sm_idle_i        (sm_idle),
    .rd_hdr_i         (rd_hdr),
    .tx_address_i     (tx_address_i),
    .tx_burst_count_i (tx_burst_count_i),
    .max_rd_code_i    (dev_csr_i[14:12]),  // max read request size field
    .rd_last_seg_o    (rd_last_seg),
    .rd_addr_o        (rd_addr),
    .rd_len_o         (rd_len)
  );

  avl_tx_pending_rd u_pend_rd (
    .AvlClk_i              (AvlClk_i),
    .Rstn_i                (Rstn_i),
    .rd_accept_i           (rd_accept),
    .tx_burst_count_i      (tx_burst_count_i),
    .txs_read_data_valid_i (txs_read_data_valid_i),
    .rd_slot_free_o        (rd_slot_free)
  );

  avl_tx_hdr_builder u_hdr (
    .AvlClk_i      (AvlClk_i),
    .Rstn_i        (Rstn_i),
    .wr_hdr_i      (wr_hdr),
    .rd_hdr_i      (rd_hdr),
    .msi_hdr_i     (msi_hdr),
    .rd_last_seg_i (rd_last_seg),
    .seg_addr_i    (seg_addr),
    .seg_len_i     (seg_len),
    .rd_addr_i     (rd_addr),
    .rd_len_i      (rd_len),
    .msi_addr_i    (msi_addr_i),
    .tx_req_wr_o   (tx_req_wr_o),
    .hdr_is_wr_o   (hdr_is_wr_o),
    .hdr_is_rd_o   (hdr_is_rd_o),
    .hdr_is_msi_o  (hdr_is_msi_o),
    .hdr_is_64_o   (hdr_is_64_o),
    .hdr_addr_o    (hdr_addr_o),
    .hdr_len_o     (hdr_len_o),
    .hdr_tag_o     (hdr_tag_o),
    .hdr_last_rd_o (hdr_last_rd_o)
  );

endmodule

`default_nettype wire

//--- tb_avl_tx_req_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tb_avl_tx_req_asserts
(
  input wire AvlClk_i,
  input wire Rstn_i,
  input wire tx_wait_request_o,
  input wire wr_dat_fifo_wr_req_o,
  input wire wr_dat_fifo_eop_o,
  input wire hdr_is_wr_o,
  input wire hdr_is_rd_o,
  input wire hdr_is_msi_o
);

  // only one header kind per cycle
  hdr_kind_onehot: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    $onehot0({hdr_is_wr_o, hdr_is_rd_o, hdr_is_msi_o}))
    else $error("more than one header kind in a cycle");

  eop_with_beat: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    wr_dat_fifo_eop_o |-> wr_dat_fifo_wr_req_o)
    else $error("end of packet without a write-data beat");

  // no avalon command taken while in reset
  wait_in_reset: assert property (@(posedge AvlClk_i) !Rstn_i |-> tx_wait_request_o)
    else $error("wait request low during reset");

endmodule

bind avl_tx_req_top tb_avl_tx_req_asserts u_asserts (.*);

`default_nettype wire

//--- tb_avl_tx_req.sv
`timescale 1ns/1ps
`default_nettype none

`include "avl_tx_req_macros.svh"

module tb_avl_tx_req
  import avl_tx_req_pkg::*;
();

  logic                    clk;
  logic                    rstn;
  logic                    cs;
  logic                    rd;
  logic                    wr;
  burst_cnt_t              bc;
  avl_addr_t               addr;
  logic [3:0]              cmd_used;
  logic [5:0]              wrd_used;
  logic [31:0]             dev_csr;
  logic                    master_en;
  logic [15:0]             msi_csr;
  msi_addr_t               msi_addr;
  logic [31:0]             irq_ena;
  logic [`RXM_IRQ_NUM-1:0] irq;
  logic                    rdv;
  wire                     tx_wait_request_o;
  wire                     wr_dat_fifo_wr_req_o;
  wire                     wr_dat_fifo_eop_o;
  wire                     cmd_fifo_busy_o;
  wire                     tx_req_wr_o;
  wire                     hdr_is_wr_o;
  wire                     hdr_is_rd_o;
  wire                     hdr_is_msi_o;
  wire                     hdr_is_64_o;
  msi_addr_t               hdr_addr_o;
  dw_len_t                 hdr_len_o;
  tag_t                    hdr_tag_o;
  wire                     hdr_last_rd_o;

  // observed and expected traffic
  // kind 0 is a write, 1 a read, 2 an msi and 3 a header with no kind flag
  logic [1:0] got_kind[$];
  msi_addr_t  got_addr[$];
  dw_len_t    got_len[$];
  tag_t       got_tag[$];
  logic       got_last[$];
  logic       got_64[$];
  logic       got_eop[$];
  logic [1:0] exp_kind[$];
  msi_addr_t  exp_addr[$];
  dw_len_t    exp_len[$];
  logic       exp_last[$];
  logic       exp_64[$];
  logic       exp_eop[$];
  tag_t       exp_tag = '0;  // tag of the next read header
  int         err_cnt = 0;
  int         tmo_cnt = 0;
  logic [31:0] lcg_state = 32'h8bf7cc85;

  avl_tx_req_top u_dut (
    .AvlClk_i              (clk),
    .Rstn_i                (rstn),
    .tx_chip_select_i      (cs),
    .tx_read_i             (rd),
    .tx_write_i            (wr),
    .tx_burst_count_i      (bc),
    .tx_address_i          (addr),
    .tx_wait_request_o     (tx_wait_request_o),
    .cmd_fifo_used_w_i     (cmd_used),
    .wr_dat_fifo_used_w_i  (wrd_used),
    .wr_dat_fifo_wr_req_o  (wr_dat_fifo_wr_req_o),
    .wr_dat_fifo_eop_o     (wr_dat_fifo_eop_o),
    .cmd_fifo_busy_o       (cmd_fifo_busy_o),
    .dev_csr_i             (dev_csr),
    .master_enable_i       (master_en),
    .msi_csr_i             (msi_csr),
    .msi_addr_i            (msi_addr),
    .pcie_irq_ena_i        (irq_ena),
    .rxm_irq_i             (irq),
    .txs_read_data_valid_i (rdv),
    .tx_req_wr_o           (tx_req_wr_o),
    .hdr_is_wr_o           (hdr_is_wr_o),
    .hdr_is_rd_o           (hdr_is_rd_o),
    .hdr_is_msi_o          (hdr_is_msi_o),
    .hdr_is_64_o           (hdr_is_64_o),
    .hdr_addr_o            (hdr_addr_o),
    .hdr_len_o             (hdr_len_o),
    .hdr_tag_o             (hdr_tag_o),
    .hdr_last_rd_o         (hdr_last_rd_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // header and data fifo monitor
  always @(posedge clk)
  begin
    if (rstn && tx_req_wr_o)
    begin
      got_kind.push_back(hdr_is_msi_o ? 2'd2 :
                         (hdr_is_rd_o ? 2'd1 : (hdr_is_wr_o ? 2'd0 : 2'd3)));
      got_addr.push_back(hdr_addr_o);
      got_len.push_back(hdr_len_o);
      got_tag.push_back(hdr_tag_o);
      got_last.push_back(hdr_last_rd_o);
      got_64.push_back(hdr_is_64_o);
    end
    if (rstn && wr_dat_fifo_wr_req_o)
      got_eop.push_back(wr_dat_fifo_eop_o);
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("ERR %0t %s: got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic timed_out(input string what);
    tmo_cnt++;
    $display("timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic expect_hdr(input logic [1:0] k, input msi_addr_t a, input int len,
                            input logic last, input logic is64);
    exp_kind.push_back(k);
    exp_addr.push_back(a);
    exp_len.push_back(dw_len_t'(len));
    exp_last.push_back(last);
    exp_64.push_back(is64);
  endtask

  // segment ends at burst end, page end or max payload
  task automatic model_write(input avl_addr_t a, input int n, input int mps);
    avl_addr_t p;
    avl_addr_t seg_a;
    int        sb;
    logic      seg_end;
    p = a;
    seg_a = a;
    sb = 0;
    for (int i = 0; i < n; i++)
    begin
      sb += 16;
      seg_end = (i == n - 1) || (p[11:0] == 12'hff0) || (sb == mps);
      exp_eop.push_back(seg_end);
      p += 16;
      if (seg_end)
      begin
        expect_hdr(2'd0, {32'h0, seg_a}, sb / 4, 1'b0, 1'b0);
        seg_a = p;
        sb = 0;
      end
    end
  endtask

  task automatic model_read(input avl_addr_t a, input int n, input int maxrd);
    avl_addr_t p;
    int        remain;
    int        to_page;
    int        size;
    p = a;
    remain = 16 * n;
    while (remain > 0)
    begin
      to_page = 4096 - int'(p[11:0]);
      size = remain;
      if (to_page < size)
        size = to_page;
      if (maxrd < size)
        size = maxrd;
      expect_hdr(2'd1, {32'h0, p}, size / 4, size == remain, 1'b0);
      p += size;
      remain -= size;
    end
  endtask

  task automatic compare_all();
    int         guard;
    logic [1:0] k;
    guard = 0;
    while (got_kind.size() < exp_kind.size() && guard < 2000)
    begin
      @(negedge clk);
      guard++;
    end
    if (got_kind.size() < exp_kind.size())
      timed_out("request headers");
    guard = 0;
    while (cmd_fifo_busy_o && guard < 200)
    begin
      @(negedge clk);
      guard++;
    end
    if (cmd_fifo_busy_o)
      timed_out("the FSM to go idle");
    repeat (4) @(negedge clk);
    check("header count", got_kind.size(), exp_kind.size());
    check("data beat count", got_eop.size(), exp_eop.size());
    while (exp_kind.size() > 0 && got_kind.size() > 0)
    begin
      k = exp_kind.pop_front();
      check("header kind", got_kind.pop_front(), k);
      check("header address", got_addr.pop_front(), exp_addr.pop_front());
      check("header length", got_len.pop_front(), exp_len.pop_front());
      check("last read flag", got_last.pop_front(), exp_last.pop_front());
      check("64-bit flag", got_64.pop_front(), exp_64.pop_front());
      if (k == 2'd1)
      begin
        check("read tag", got_tag.pop_front(), exp_tag);
        exp_tag++;
      end
      else
        void'(got_tag.pop_front());
    end
    while (exp_eop.size() > 0 && got_eop.size() > 0)
      check("end of packet", got_eop.pop_front(), exp_eop.pop_front());
    got_kind.delete();
    got_addr.delete();
    got_len.delete();
    got_tag.delete();
    got_last.delete();
    got_64.delete();
    got_eop.delete();
    exp_kind.delete();
    exp_addr.delete();
    exp_len.delete();
    exp_last.delete();
    exp_64.delete();
    exp_eop.delete();
  endtask

  task automatic run_write(input avl_addr_t a, input int n);
    int   beats;
    int   guard;
    logic acc;
    model_write(a, n, (dev_csr[7:5] == 3'd0) ? 128 : 256);
    @(negedge clk);
    cs = 1'b1;
    wr = 1'b1;
    addr = a;
    bc = burst_cnt_t'(n);
    beats = 0;
    guard = 0;
    while (beats < n && guard < 500)
    begin
      #1 acc = !tx_wait_request_o;  // beat is taken at the coming rising edge
      if (acc)
        check("command fifo busy during a write beat", cmd_fifo_busy_o, 1'b1);
      @(negedge clk);
      if (acc)
        beats++;
      guard++;
    end
    if (beats < n)
      timed_out("write beats to be accepted");
    cs = 1'b0;
    wr = 1'b0;
    compare_all();
  endtask

  task automatic start_read(input avl_addr_t a, input int n);
    model_read(a, n, (dev_csr[14:12] == 3'd0) ? 128 :
                     ((dev_csr[14:12] == 3'd1) ? 256 : 512));
    @(negedge clk);
    cs = 1'b1;
    rd = 1'b1;
    addr = a;
    bc = burst_cnt_t'(n);
  endtask

  task automatic wait_read_accept();
    int   guard;
    logic acc;
    guard = 0;
    acc = 1'b0;
    while (!acc && guard < 500)
    begin
      #1 acc = !tx_wait_request_o;
      @(negedge clk);
      guard++;
    end
    if (!acc)
      timed_out("a read command to be accepted");
    cs = 1'b0;
    rd = 1'b0;
  endtask

  task automatic return_data(input int n);
    repeat (n)
    begin
      @(negedge clk);
      rdv = 1'b1;
    end
    @(negedge clk);
    rdv = 1'b0;
  endtask

  task automatic test_single_write();
    int        n;
    logic [31:0] r;
    repeat (3)
    begin
      n = 1 + int'(lcg_next() % 8);
      r = lcg_next();
      run_write({r[31:12], 12'h0} + avl_addr_t'((lcg_next() % (256 - n)) * 16), n);
    end
  endtask

  task automatic test_reads();
    logic [31:0] r;
    r = lcg_next();
    start_read({r[31:12], 12'h000}, 32);
    wait_read_accept();
    compare_all();
    return_data(32);
    r = lcg_next();
    start_read({r[31:12], 12'hfc0}, 8);  // 64 bytes below the boundary
    wait_read_accept();
    compare_all();
    return_data(8);
  endtask

  task automatic test_outstanding();
    logic [31:0] r;
    repeat (8)
    begin
      r = lcg_next();
      start_read({r[31:12], r[11:5], 5'h0}, 2);
      wait_read_accept();
      compare_all();
    end
    r = lcg_next();
    start_read({r[31:12], r[11:5], 5'h0}, 2);
    repeat (60)
    begin
      #1 check("wait request with reads full", tx_wait_request_o, 1'b1);
      @(negedge clk);
    end
    return_data(2);
    wait_read_accept();
    compare_all();
    return_data(16);
  endtask

  task automatic test_msi();
    irq_ena = 32'hf;
    msi_csr = 16'h0001;
    msi_addr = 64'h0000_0001_fee0_1000;
    @(negedge clk);
    irq[0] = 1'b1;
    expect_hdr(2'd2, msi_addr, 1, 1'b0, 1'b1);
    compare_all();
    irq = '0;
    msi_addr = 64'h0000_0000_fee0_2000;
    @(negedge clk);
    irq[2] = 1'b1;
    expect_hdr(2'd2, msi_addr, 1, 1'b0, 1'b0);
    compare_all();
    irq = '0;
    msi_csr = 16'h0000;  // edges are ignored with msi off
    @(negedge clk);
    irq[1] = 1'b1;
    repeat (20) @(negedge clk);
    check("header count with msi disabled", got_kind.size(), 0);
    irq = '0;
  endtask

  initial
  begin
    repeat (60000) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    rstn = 1'b0;
    cs = 1'b0;
    rd = 1'b0;
    wr = 1'b0;
    bc = '0;
    addr = '0;
    cmd_used = '0;
    wrd_used = '0;
    dev_csr = '0;
    master_en = 1'b1;
    msi_csr = '0;
    msi_addr = '0;
    irq_ena = '0;
    irq = '0;
    rdv = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    repeat (4) @(negedge clk);
    check("wait request after reset", tx_wait_request_o, 1'b1);
    check("data fifo write after reset", wr_dat_fifo_wr_req_o, 1'b0);
    check("end of packet after reset", wr_dat_fifo_eop_o, 1'b0);
    check("header write after reset", tx_req_wr_o, 1'b0);
    check("command fifo busy after reset", cmd_fifo_busy_o, 1'b0);
    test_single_write();
    run_write({lcg_state[31:12], 12'h000}, 20);  // payload split at 128 bytes
    run_write({lcg_next() & 32'hffff_f000} | 32'hfd0, 8);
    test_reads();
    test_outstanding();
    test_msi();
    $display("checks done, %0d value errors, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- avl_tx_req.f
+incdir+.
avl_tx_req_pkg.sv
avl_tx_req_fsm.sv
avl_tx_wr_segmenter.sv
avl_tx_rd_segmenter.sv
avl_tx_pending_rd.sv
avl_tx_hdr_builder.sv
avl_tx_req_top.sv
tb_avl_tx_req_asserts.sv
tb_avl_tx_req.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_avl_tx_req -f avl_tx_req.f -o sim_avl_tx_req

./obj_dir/sim_avl_tx_req > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
